// File: hdl/inst_queue.sv
module inst_queue #(
  parameter int DEPTH = rv_pkg::IQ_DEPTH
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              push_i,
  input  rv_pkg::iq_entry_t push_data_i,
  output logic              space_ok_o,
  output logic              head_valid_o,
  output rv_pkg::iq_entry_t head_data_o,
  input  logic              pop_i,
  input  logic              flush_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  rv_pkg::iq_entry_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign space_ok_o   = (count != DEPTH[PTR_W:0]);
  assign head_valid_o = (count != '0);
  assign head_data_o  = mem[rd_ptr];

  assign do_push = push_i && space_ok_o;
  assign do_pop  = pop_i && head_valid_o;

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

// File: hdl/rv_core.sv
module rv_core (
  input  logic                          clk,
  input  logic                          rst,
  output logic                          imem_req_o,
  output logic [rv_pkg::XLEN-1:0]       imem_addr_o,
  input  logic                          imem_valid_i,
  input  logic [31:0]                   imem_data_i,
  output logic                          retire_valid_o,
  output logic [rv_pkg::XLEN-1:0]       retire_pc_o,
  output logic                          retire_we_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [rv_pkg::XLEN-1:0]       retire_data_o,
  output logic                          halt_o
);

  logic                    push;
  rv_pkg::iq_entry_t       push_data;
  logic                    space_ok;
  logic                    head_valid;
  rv_pkg::iq_entry_t       head_data;
  logic                    pop;
  logic                    redirect;
  logic [rv_pkg::XLEN-1:0] redirect_pc;

  rv_fetch fetch_i (
    .clk           (clk),
    .rst           (rst),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_valid_i  (imem_valid_i),
    .imem_data_i   (imem_data_i),
    .space_ok_i    (space_ok),
    .push_o        (push),
    .push_data_o   (push_data),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc)
  );

  // Redirect also flushes wrong-path entries
  inst_queue #(
    .DEPTH (rv_pkg::IQ_DEPTH)
  ) queue_i (
    .clk          (clk),
    .rst          (rst),
    .push_i       (push),
    .push_data_i  (push_data),
    .space_ok_o   (space_ok),
    .head_valid_o (head_valid),
    .head_data_o  (head_data),
    .pop_i        (pop),
    .flush_i      (redirect)
  );

  rv_exec exec_i (
    .clk            (clk),
    .rst            (rst),
    .head_valid_i   (head_valid),
    .head_data_i    (head_data),
    .pop_o          (pop),
    .redirect_o     (redirect),
    .redirect_pc_o  (redirect_pc),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_we_o    (retire_we_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o),
    .halt_o         (halt_o)
  );

endmodule

// File: hdl/rv_exec.sv
module rv_exec (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          head_valid_i,
  input  rv_pkg::iq_entry_t             head_data_i,
  output logic                          pop_o,
  output logic                          redirect_o,
  output logic [rv_pkg::XLEN-1:0]       redirect_pc_o,
  output logic                          retire_valid_o,
  output logic [rv_pkg::XLEN-1:0]       retire_pc_o,
  output logic                          retire_we_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd_o,
  output logic [rv_pkg::XLEN-1:0]       retire_data_o,
  output logic                          halt_o
);

  logic [31:0]                   inst;
  logic [rv_pkg::XLEN-1:0]       pc;
  logic [6:0]                    opcode;
  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic [rv_pkg::REG_ADDR_W-1:0] rs1;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2;
  logic [rv_pkg::REG_ADDR_W-1:0] rd;
  logic [rv_pkg::XLEN-1:0]       imm_i;
  logic [rv_pkg::XLEN-1:0]       imm_u;
  logic [rv_pkg::XLEN-1:0]       imm_j;
  logic [rv_pkg::XLEN-1:0]       imm_b;
  logic [rv_pkg::XLEN-1:0]       src1;
  logic [rv_pkg::XLEN-1:0]       src2;
  logic [rv_pkg::XLEN-1:0]       wb_data;
  logic                          wb_en;
  logic                          taken;
  logic [rv_pkg::XLEN-1:0]       target;
  logic                          is_ebreak;

  assign inst   = head_data_i.inst;
  assign pc     = head_data_i.pc;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // RV32E has 16 registers so the upper index bit is dropped
  assign rs1 = inst[15 +: rv_pkg::REG_ADDR_W];
  assign rs2 = inst[20 +: rv_pkg::REG_ADDR_W];
  assign rd  = inst[7 +: rv_pkg::REG_ADDR_W];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  assign pop_o = head_valid_i && !redirect_o && !halt_o;

  rv_regfile regs_i (
    .clk      (clk),
    .rst      (rst),
    .we_i     (pop_o && wb_en),
    .waddr_i  (rd),
    .wdata_i  (wb_data),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (src1),
    .rdata2_o (src2)
  );

  always_comb
  begin
    wb_data   = '0;
    wb_en     = 1'b0;
    taken     = 1'b0;
    target    = pc + imm_b;
    is_ebreak = 1'b0;
    case (opcode)
      rv_pkg::OP_IMM:
      begin
        // ADDI is the only immediate op
        wb_en   = (funct3 == rv_pkg::F3_ADD_SUB);
        wb_data = src1 + imm_i;
      end
      rv_pkg::OP_REG:
      begin
        // Only SUB uses a nonzero funct7
        wb_en = (funct7 == 7'b0) ||
                (funct3 == rv_pkg::F3_ADD_SUB && funct7 == rv_pkg::F7_SUB);
        case (funct3)
          rv_pkg::F3_ADD_SUB:
            wb_data = (funct7 == rv_pkg::F7_SUB) ? src1 - src2 : src1 + src2;
          rv_pkg::F3_XOR: wb_data = src1 ^ src2;
          rv_pkg::F3_OR:  wb_data = src1 | src2;
          rv_pkg::F3_AND: wb_data = src1 & src2;
          default:        wb_en = 1'b0;
        endcase
      end
      rv_pkg::OP_LUI:
      begin
        wb_en   = 1'b1;
        wb_data = imm_u;
      end
      rv_pkg::OP_JAL:
      begin
        // Link address goes to rd
        wb_en   = 1'b1;
        wb_data = pc + 32'd4;
        taken   = 1'b1;
        target  = pc + imm_j;
      end
      rv_pkg::OP_BRANCH:
      begin
        if (funct3 == rv_pkg::F3_BEQ)
          taken = (src1 == src2);
        else if (funct3 == rv_pkg::F3_BNE)
          taken = (src1 != src2);
      end
      rv_pkg::OP_SYSTEM:
        is_ebreak = (inst[31:20] == rv_pkg::F12_EBREAK) && (inst[19:7] == '0);
      default: ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      retire_valid_o <= 1'b0;
      retire_we_o    <= 1'b0;
      redirect_o     <= 1'b0;
      halt_o         <= 1'b0;
    end
    else
    begin
      retire_valid_o <= pop_o;
      retire_we_o    <= pop_o && wb_en;
      redirect_o     <= pop_o && taken;
      if (pop_o && is_ebreak)
        halt_o <= 1'b1;
    end
  end

  // Retire record and jump target
  always_ff @(posedge clk)
  begin
    if (pop_o)
    begin
      retire_pc_o   <= pc;
      retire_rd_o   <= rd;
      retire_data_o <= wb_data;
      redirect_pc_o <= target;
    end
  end

endmodule

// File: hdl/rv_fetch.sv
module rv_fetch (
  input  logic                       clk,
  input  logic                       rst,
  output logic                       imem_req_o,
  output logic [rv_pkg::XLEN-1:0]    imem_addr_o,
  input  logic                       imem_valid_i,
  input  logic [31:0]                imem_data_i,
  input  logic                       space_ok_i,
  output logic                       push_o,
  output rv_pkg::iq_entry_t          push_data_o,
  input  logic                       redirect_i,
  input  logic [rv_pkg::XLEN-1:0]    redirect_pc_i
);

  logic [rv_pkg::XLEN-1:0] pc_q;
  logic                    req_q;
  logic                    outstanding_q;
  logic                    drop_q;
  logic                    issue;

  // One read in flight at a time, and only with a free queue slot
  assign issue = !outstanding_q && space_ok_i && !redirect_i;

  // Stale responses and responses landing on a redirect are discarded
  assign push_o = imem_valid_i && !drop_q && !redirect_i;

  assign push_data_o.pc   = pc_q;
  assign push_data_o.inst = imem_data_i;

  assign imem_req_o  = req_q;
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q          <= rv_pkg::PC_INIT;
      req_q         <= 1'b0;
      outstanding_q <= 1'b0;
      drop_q        <= 1'b0;
    end
    else
    begin
      req_q <= issue;
      if (issue)
        outstanding_q <= 1'b1;
      else if (imem_valid_i)
        outstanding_q <= 1'b0;

      if (redirect_i)
      begin
        pc_q <= redirect_pc_i;
        // Response still pending belongs to the old stream
        drop_q <= outstanding_q && !imem_valid_i;
      end
      else if (imem_valid_i)
      begin
        drop_q <= 1'b0;
        if (!drop_q)
          pc_q <= pc_q + 32'd4;
      end
    end
  end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_NUM    = 16;
  localparam int REG_ADDR_W = 4;

  localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0000;

  // Default instruction queue depth
  localparam int IQ_DEPTH = 4;

  // Major opcodes
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // funct3 codes
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // funct7 selecting SUB over ADD
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // funct12 of EBREAK
  localparam logic [11:0] F12_EBREAK = 12'h001;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
  } iq_entry_t;

endpackage

// File: hdl/rv_regfile.sv
module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_pkg::XLEN-1:0]       wdata_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] raddr1_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] raddr2_i,
  output logic [rv_pkg::XLEN-1:0]       rdata1_o,
  output logic [rv_pkg::XLEN-1:0]       rdata2_o
);

  logic [rv_pkg::XLEN-1:0] rf [rv_pkg::REG_NUM];

  // x0 is hardwired
  assign rdata1_o = (raddr1_i == '0) ? '0 : rf[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : rf[raddr2_i];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < rv_pkg::REG_NUM; i++)
        rf[i] <= '0;
    end
    else if (we_i && waddr_i != '0)
    begin
      rf[waddr_i] <= wdata_i;
    end
  end

endmodule

// File: project.f
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_fetch.sv
hdl/inst_queue.sv
hdl/rv_exec.sv
hdl/rv_core.sv
tb/tb_core.sv

// File: run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --top-module tb_core -f project.f -o tb_core_sim || exit 1
./obj_dir/tb_core_sim 2>&1 | tee sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

// File: tb/core_golden.txt
# I <word addr> <inst>, E <pc> <we> <rd> <data>, T <test name>
# All numbers are hex
I 00 00500093
I 01 ffd00113
I 02 002081b3
I 03 40208233
I 04 0020f2b3
I 05 0020e333
I 06 0020c3b3
I 07 12345437
I 08 67840413
I 09 00708013
I 0a 008004b3
I 0b 00008533
I 0c 00c005ef
I 0d 11100613
I 0e 22200613
I 0f 00158613
I 10 00a08463
I 11 7ff00693
I 12 00a09463
I 13 00300693
I 14 fff68693
I 15 00270713
I 16 fe069ce3
I 17 00d707b3
I 18 00100073
I 19 00100093
I 1a 00200113
T alu_ops
E 00000000 1 1 00000005
E 00000004 1 2 fffffffd
E 00000008 1 3 00000002
E 0000000c 1 4 00000008
E 00000010 1 5 00000005
E 00000014 1 6 fffffffd
E 00000018 1 7 fffffff8
E 0000001c 1 8 12345000
E 00000020 1 8 12345678
T x0_writes
E 00000024 1 0 0000000c
E 00000028 1 9 12345678
E 0000002c 1 a 00000005
T jal_skip
E 00000030 1 b 00000034
E 0000003c 1 c 00000035
T branches
E 00000040 0 0 00000000
E 00000048 0 0 00000000
E 0000004c 1 d 00000003
E 00000050 1 d 00000002
E 00000054 1 e 00000002
E 00000058 0 0 00000000
E 00000050 1 d 00000001
E 00000054 1 e 00000004
E 00000058 0 0 00000000
E 00000050 1 d 00000000
E 00000054 1 e 00000006
E 00000058 0 0 00000000
T ebreak_halt
E 0000005c 1 f 00000006
E 00000060 0 0 00000000

// File: tb/tb_core.sv
module tb_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 256;
  localparam int QUIET_CYCLES = 50;

  logic        clk;
  logic        rst;
  logic        imem_req;
  logic [31:0] imem_addr;
  logic        imem_valid;
  logic [31:0] imem_data;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic        retire_we;
  logic [3:0]  retire_rd;
  logic [31:0] retire_data;
  logic        halt;

  logic [31:0]      mem [MEM_WORDS];
  logic [31:0]      exp_pc [$];
  logic [31:0]      exp_we [$];
  logic [31:0]      exp_rd [$];
  logic [31:0]      exp_data [$];
  logic [8*16-1:0]  test_names [$];
  int               test_first [$];

  int          n_exp;
  int          n_ret;
  int          errors;
  int          test_idx;
  int          test_err_base;
  int          tests_passed;
  int          tests_failed;
  int          cycles;
  int          limit;
  bit          golden_ok;
  logic        pending;
  logic [31:0] pend_addr;
  int unsigned wait_left;

  rv_core dut_i (
    .clk            (clk),
    .rst            (rst),
    .imem_req_o     (imem_req),
    .imem_addr_o    (imem_addr),
    .imem_valid_i   (imem_valid),
    .imem_data_i    (imem_data),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_we_o    (retire_we),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data),
    .halt_o         (halt)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Unloaded words decode as unsupported opcode 0
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx, 8'ha5, ~idx, idx[0], 7'b0000000};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      errors++;
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic load_golden(output bit ok);
    int              fd;
    int              code;
    logic [7:0]      tag;
    logic [8*128-1:0] rest;
    logic [8*16-1:0] name;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     c;
    logic [31:0]     d;
    fd = $fopen("tb/core_golden.txt", "r");
    ok = (fd != 0);
    if (fd != 0)
    begin
      code = $fscanf(fd, "%s", tag);
      while (code == 1)
      begin
        if (tag == "#")
          code = $fgets(rest, fd);
        else if (tag == "I")
        begin
          code = $fscanf(fd, "%h %h", a, b);
          mem[a[7:0]] = b;
        end
        else if (tag == "E")
        begin
          code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          exp_pc.push_back(a);
          exp_we.push_back(b);
          exp_rd.push_back(c);
          exp_data.push_back(d);
        end
        else if (tag == "T")
        begin
          code = $fscanf(fd, "%s", name);
          test_names.push_back(name);
          test_first.push_back(exp_pc.size());
        end
        code = $fscanf(fd, "%s", tag);
      end
      $fclose(fd);
    end
  endtask

  task automatic finish_test;
    int errs;
    errs = errors - test_err_base;
    if (errs == 0)
    begin
      $display("Test %0s passed", test_names[test_idx]);
      tests_passed++;
    end
    else
    begin
      $display("Test %0s failed with %0d errors", test_names[test_idx], errs);
      tests_failed++;
    end
    test_err_base = errors;
    test_idx++;
  endtask

  // Memory model answers each request after 1 to 4 cycles
  always @(posedge clk)
  begin
    if (rst)
    begin
      imem_valid <= 1'b0;
      imem_data  <= '0;
      pending = 1'b0;
    end
    else
    begin
      imem_valid <= 1'b0;
      if (imem_req)
      begin
        if (pending)
        begin
          errors++;
          $display("Fetch issued a second request while one was outstanding");
        end
        pending = 1'b1;
        pend_addr = imem_addr;
        wait_left = $urandom_range(0, 3);
      end
      if (pending)
      begin
        if (wait_left == 0)
        begin
          imem_valid <= 1'b1;
          imem_data  <= mem[pend_addr[9:2]];
          pending = 1'b0;
        end
        else
          wait_left--;
      end
    end
  end

  // Retire checker
  always @(posedge clk)
  begin
    if (!rst && retire_valid === 1'b1)
    begin
      if (n_ret >= n_exp)
      begin
        errors++;
        n_ret++;
        $display("Unexpected retirement at pc %h after the last expected one", retire_pc);
      end
      else
      begin
        check_value("retire_pc_o", exp_pc[n_ret], retire_pc);
        check_value("retire_we_o", exp_we[n_ret], {31'b0, retire_we});
        // Destination fields only mean something on a write
        if (exp_we[n_ret] != 0)
        begin
          check_value("retire_rd_o", exp_rd[n_ret], {28'b0, retire_rd});
          check_value("retire_data_o", exp_data[n_ret], retire_data);
        end
        n_ret++;
        if (test_idx + 1 < test_names.size() && n_ret == test_first[test_idx + 1])
          finish_test();
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= limit)
    begin
      $display("Timeout after %0d cycles, %0d of %0d retirements seen", cycles, n_ret, n_exp);
      $display("Testbench failed");
      $finish;
    end
  end

  initial
  begin
    rst = 1'b1;
    imem_valid = 1'b0;
    imem_data = '0;
    pending = 1'b0;
    pend_addr = '0;
    wait_left = 0;
    n_ret = 0;
    errors = 0;
    test_idx = 0;
    test_err_base = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles = 0;
    void'($urandom(32'h8ccf));
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = fill_word(i[7:0]);
    load_golden(golden_ok);
    if (!golden_ok)
    begin
      $display("Could not open tb/core_golden.txt");
      $display("Testbench failed");
      $finish;
    end
    else
    begin
      n_exp = exp_pc.size();
      limit = n_exp * 8 + 200;

      repeat (10) @(posedge clk);
      rst <= 1'b0;

      while (n_ret < n_exp)
        @(negedge clk);
      check_value("halt_o", 32'd1, {31'b0, halt});
      // Core must stay silent once halted
      repeat (QUIET_CYCLES) @(negedge clk);
      check_value("retire count", n_exp, n_ret);
      finish_test();

      $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
        $display("Testbench passed");
      else
        $display("Testbench failed");
      $finish;
    end
  end

endmodule
